// ==== verilog/remap_consts.svh ====
// width and table size constants for the AXI address remapper
`ifndef REMAP_CONSTS_SVH
`define REMAP_CONSTS_SVH

// address spaces
`define REMAP_SLV_ADDR_W 32 // upstream (slave port) address width
`define REMAP_MST_ADDR_W 40 // downstream (master port) address width

// AXI side fields
`define REMAP_ID_W       4  // transaction id width, same on both ports
`define REMAP_DATA_W     64 // data bus width
`define REMAP_USER_W     2  // user sideband width on every channel

// rule table
`define REMAP_NUM_RULES  4  // entries in the page rule table, index 0 wins

// AXI field widths fixed by the protocol
`define REMAP_LEN_W      8
`define REMAP_SIZE_W     3
`define REMAP_BURST_W    2
`define REMAP_CACHE_W    4
`define REMAP_PROT_W     3
`define REMAP_QOS_W      4
`define REMAP_REGION_W   4
`define REMAP_ATOP_W     6
`define REMAP_RESP_W     2

`endif

// ==== verilog/remap_pkg.sv ====
// AXI channel, request/response and remap rule types for the address remapper
`include "remap_consts.svh"

package remap_pkg;

  // basic field types
  typedef logic [`REMAP_SLV_ADDR_W-1:0]   slv_addr_t; // upstream address
  typedef logic [`REMAP_MST_ADDR_W-1:0]   mst_addr_t; // widened downstream address
  typedef logic [`REMAP_ID_W-1:0]         id_t;
  typedef logic [`REMAP_DATA_W-1:0]       data_t;
  typedef logic [`REMAP_DATA_W/8-1:0]     strb_t;     // one strobe per byte
  typedef logic [`REMAP_USER_W-1:0]       user_t;
  typedef logic [$clog2(`REMAP_NUM_RULES)-1:0] rule_idx_t;

  // AW channel, slave side
  typedef struct packed {
    id_t                         id;
    slv_addr_t                   addr;
    logic [`REMAP_LEN_W-1:0]     len;
    logic [`REMAP_SIZE_W-1:0]    size;
    logic [`REMAP_BURST_W-1:0]   burst;
    logic                        lock;
    logic [`REMAP_CACHE_W-1:0]   cache;
    logic [`REMAP_PROT_W-1:0]    prot;
    logic [`REMAP_QOS_W-1:0]     qos;
    logic [`REMAP_REGION_W-1:0]  region;
    logic [`REMAP_ATOP_W-1:0]    atop;  // atomic op, AW only
    user_t                       user;
  } slv_aw_chan_t;

  // AW channel, master side, same fields with the wide address
  typedef struct packed {
    id_t                         id;
    mst_addr_t                   addr;
    logic [`REMAP_LEN_W-1:0]     len;
    logic [`REMAP_SIZE_W-1:0]    size;
    logic [`REMAP_BURST_W-1:0]   burst;
    logic                        lock;
    logic [`REMAP_CACHE_W-1:0]   cache;
    logic [`REMAP_PROT_W-1:0]    prot;
    logic [`REMAP_QOS_W-1:0]     qos;
    logic [`REMAP_REGION_W-1:0]  region;
    logic [`REMAP_ATOP_W-1:0]    atop;
    user_t                       user;
  } mst_aw_chan_t;

  // AR channel, slave side (no atop)
  typedef struct packed {
    id_t                         id;
    slv_addr_t                   addr;
    logic [`REMAP_LEN_W-1:0]     len;
    logic [`REMAP_SIZE_W-1:0]    size;
    logic [`REMAP_BURST_W-1:0]   burst;
    logic                        lock;
    logic [`REMAP_CACHE_W-1:0]   cache;
    logic [`REMAP_PROT_W-1:0]    prot;
    logic [`REMAP_QOS_W-1:0]     qos;
    logic [`REMAP_REGION_W-1:0]  region;
    user_t                       user;
  } slv_ar_chan_t;

  // AR channel, master side
  typedef struct packed {
    id_t                         id;
    mst_addr_t                   addr;
    logic [`REMAP_LEN_W-1:0]     len;
    logic [`REMAP_SIZE_W-1:0]    size;
    logic [`REMAP_BURST_W-1:0]   burst;
    logic                        lock;
    logic [`REMAP_CACHE_W-1:0]   cache;
    logic [`REMAP_PROT_W-1:0]    prot;
    logic [`REMAP_QOS_W-1:0]     qos;
    logic [`REMAP_REGION_W-1:0]  region;
    user_t                       user;
  } mst_ar_chan_t;

  // data and response channels, identical on both ports
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
    user_t user;
  } w_chan_t;

  typedef struct packed {
    id_t                       id;
    logic [`REMAP_RESP_W-1:0]  resp;
    user_t                     user;
  } b_chan_t;

  typedef struct packed {
    id_t                       id;
    data_t                     data;
    logic [`REMAP_RESP_W-1:0]  resp;
    logic                      last;
    user_t                     user;
  } r_chan_t;

  // request bundles, one per address width
  typedef struct packed {
    slv_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    slv_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } slv_req_t;

  typedef struct packed {
    mst_aw_chan_t aw;
    logic         aw_valid;
    w_chan_t      w;
    logic         w_valid;
    logic         b_ready;
    mst_ar_chan_t ar;
    logic         ar_valid;
    logic         r_ready;
  } mst_req_t;

  // response bundle, shared by both ports
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    r_valid;
    r_chan_t r;
  } resp_t;

  // one page rule: hit when (addr & mask) == (base & mask)
  typedef struct packed {
    logic      valid;
    slv_addr_t base;
    slv_addr_t mask;   // set bits select the page
    mst_addr_t target; // replaces the masked bits on a hit
  } rule_t;

  // configuration write, single cycle strobe
  typedef struct packed {
    logic      en;
    rule_idx_t idx;
    rule_t     rule;
  } rule_cfg_t;

endpackage

// ==== verilog/remap_rule_regs.sv ====
// rule table register file with a single-cycle configuration write port
`timescale 1ns/1ns
`include "remap_consts.svh"

module remap_rule_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,  // sync, active low
  input  remap_pkg::rule_cfg_t  cfg_i,    // en strobe + index + full rule
  output remap_pkg::rule_t      rules_o [`REMAP_NUM_RULES]
);

  remap_pkg::rule_t rule_q [`REMAP_NUM_RULES]; // table storage

  // write replaces the whole entry, valid bit included
  // reset only has to knock out the valid bits, base/mask/target are
  // don't-care while an entry is invalid
  always_ff @(posedge clk_i) begin
    if (cfg_i.en) begin
      rule_q[cfg_i.idx] <= cfg_i.rule; // one entry per strobe
    end
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < `REMAP_NUM_RULES; i++) begin
        rule_q[i].valid <= 1'b0;       // wins over a write in the same cycle
      end
    end
  end

  // table straight from the flops, new rule seen the cycle after the edge
  always_comb begin
    for (int unsigned i = 0; i < `REMAP_NUM_RULES; i++) begin
      rules_o[i] = rule_q[i];
    end
  end

endmodule

// ==== verilog/addr_translate.sv ====
// priority page rule match and page substitution for one address
`timescale 1ns/1ns
`include "remap_consts.svh"

module addr_translate (
  input  remap_pkg::rule_t     rules_i [`REMAP_NUM_RULES], // shared rule table
  input  remap_pkg::slv_addr_t addr_i,                     // narrow request address
  output remap_pkg::mst_addr_t addr_o                      // widened, maybe remapped
);

  logic [`REMAP_NUM_RULES-1:0] match;                       // per-rule hit
  remap_pkg::mst_addr_t        subst [`REMAP_NUM_RULES];    // per-rule result
  remap_pkg::mst_addr_t        addr_ext;                    // zero-extended input
  remap_pkg::mst_addr_t        mask_ext;                    // scratch, widened mask

  assign addr_ext = remap_pkg::mst_addr_t'(addr_i);

  // all rules compared in parallel
  always_comb begin
    mask_ext = '0;
    for (int unsigned i = 0; i < `REMAP_NUM_RULES; i++) begin
      match[i] = rules_i[i].valid &&
                 ((addr_i & rules_i[i].mask) == (rules_i[i].base & rules_i[i].mask));
      // mask is zero-extended too, so bits above the slave width stay 0
      mask_ext = remap_pkg::mst_addr_t'(rules_i[i].mask);
      subst[i] = (rules_i[i].target & mask_ext) | (addr_ext & ~mask_ext);
    end
  end

  // lowest index wins, walk down so index 0 is applied last
  always_comb begin
    addr_o = addr_ext; // no hit -> identity
    for (int i = `REMAP_NUM_RULES - 1; i >= 0; i--) begin
      if (match[i]) begin
        addr_o = subst[i];
      end
    end
  end

endmodule

// ==== verilog/axi_modify_address.sv ====
// AXI request address replacement with pass-through of all other fields
`timescale 1ns/1ns

module axi_modify_address #(
  parameter type slv_addr_t = logic, // upstream address
  parameter type slv_req_t  = logic, // upstream request bundle
  parameter type mst_addr_t = logic, // downstream address
  parameter type mst_req_t  = logic, // downstream request bundle
  parameter type resp_t     = logic  // response, same on both sides
) (
  // upstream side
  input  slv_req_t  slv_req_i,
  output resp_t     slv_resp_o,
  output slv_addr_t slv_aw_addr_o,  // to the AW translator
  output slv_addr_t slv_ar_addr_o,  // to the AR translator
  // downstream side
  output mst_req_t  mst_req_o,
  input  resp_t     mst_resp_i,
  input  mst_addr_t mst_aw_addr_i,  // translated AW address
  input  mst_addr_t mst_ar_addr_i   // translated AR address
);

  // expose the raw addresses for lookup
  assign slv_aw_addr_o = slv_req_i.aw.addr;
  assign slv_ar_addr_o = slv_req_i.ar.addr;

  // rebuild the request field by field, only addr is swapped
  always_comb begin
    // write address
    mst_req_o.aw.id     = slv_req_i.aw.id;
    mst_req_o.aw.addr   = mst_aw_addr_i;
    mst_req_o.aw.len    = slv_req_i.aw.len;
    mst_req_o.aw.size   = slv_req_i.aw.size;
    mst_req_o.aw.burst  = slv_req_i.aw.burst;
    mst_req_o.aw.lock   = slv_req_i.aw.lock;
    mst_req_o.aw.cache  = slv_req_i.aw.cache;
    mst_req_o.aw.prot   = slv_req_i.aw.prot;
    mst_req_o.aw.qos    = slv_req_i.aw.qos;
    mst_req_o.aw.region = slv_req_i.aw.region;
    mst_req_o.aw.atop   = slv_req_i.aw.atop;
    mst_req_o.aw.user   = slv_req_i.aw.user;
    mst_req_o.aw_valid  = slv_req_i.aw_valid;   // handshake untouched
    // write data and response ready
    mst_req_o.w         = slv_req_i.w;          // same type both sides
    mst_req_o.w_valid   = slv_req_i.w_valid;
    mst_req_o.b_ready   = slv_req_i.b_ready;
    // read address
    mst_req_o.ar.id     = slv_req_i.ar.id;
    mst_req_o.ar.addr   = mst_ar_addr_i;
    mst_req_o.ar.len    = slv_req_i.ar.len;
    mst_req_o.ar.size   = slv_req_i.ar.size;
    mst_req_o.ar.burst  = slv_req_i.ar.burst;
    mst_req_o.ar.lock   = slv_req_i.ar.lock;
    mst_req_o.ar.cache  = slv_req_i.ar.cache;
    mst_req_o.ar.prot   = slv_req_i.ar.prot;
    mst_req_o.ar.qos    = slv_req_i.ar.qos;
    mst_req_o.ar.region = slv_req_i.ar.region;
    mst_req_o.ar.user   = slv_req_i.ar.user;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    mst_req_o.r_ready   = slv_req_i.r_ready;
  end

  // response path is a plain wire back upstream
  assign slv_resp_o = mst_resp_i;

endmodule

// ==== verilog/axi_addr_remap_top.sv ====
// AXI address remapper top: rule table, AW/AR translators and address modifier
`timescale 1ns/1ns
`include "remap_consts.svh"

module axi_addr_remap_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,     // sync, active low
  input  remap_pkg::rule_cfg_t  cfg_i,       // rule table write port
  // upstream AXI (32-bit address)
  input  remap_pkg::slv_req_t   slv_req_i,
  output remap_pkg::resp_t      slv_resp_o,
  // downstream AXI (40-bit address)
  output remap_pkg::mst_req_t   mst_req_o,
  input  remap_pkg::resp_t      mst_resp_i
);

  remap_pkg::rule_t     rules [`REMAP_NUM_RULES]; // table, read by both lookups
  remap_pkg::slv_addr_t slv_aw_addr;             // raw AW address
  remap_pkg::slv_addr_t slv_ar_addr;             // raw AR address
  remap_pkg::mst_addr_t mst_aw_addr;             // translated AW address
  remap_pkg::mst_addr_t mst_ar_addr;             // translated AR address

  // rule storage
  remap_rule_regs i_rule_regs (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .cfg_i   ( cfg_i   ),
    .rules_o ( rules   )
  );

  // write address lookup
  addr_translate i_aw_translate (
    .rules_i ( rules       ),
    .addr_i  ( slv_aw_addr ),
    .addr_o  ( mst_aw_addr )
  );

  // read address lookup, runs in parallel with AW
  addr_translate i_ar_translate (
    .rules_i ( rules       ),
    .addr_i  ( slv_ar_addr ),
    .addr_o  ( mst_ar_addr )
  );

  // splices the translated addresses into the outgoing request
  axi_modify_address #(
    .slv_addr_t ( remap_pkg::slv_addr_t ),
    .slv_req_t  ( remap_pkg::slv_req_t  ),
    .mst_addr_t ( remap_pkg::mst_addr_t ),
    .mst_req_t  ( remap_pkg::mst_req_t  ),
    .resp_t     ( remap_pkg::resp_t     )
  ) i_modify_address (
    .slv_req_i     ( slv_req_i   ),
    .slv_resp_o    ( slv_resp_o  ),
    .slv_aw_addr_o ( slv_aw_addr ),
    .slv_ar_addr_o ( slv_ar_addr ),
    .mst_req_o     ( mst_req_o   ),
    .mst_resp_i    ( mst_resp_i  ),
    .mst_aw_addr_i ( mst_aw_addr ),
    .mst_ar_addr_i ( mst_ar_addr )
  );

endmodule

// ==== dv/remap_sva.sv ====
// bound assertion checker for the remapper top and its bind
`timescale 1ns/1ns
`include "remap_consts.svh"

module remap_sva (
  input logic                clk_i,
  input logic                rst_n_i,
  input remap_pkg::slv_req_t slv_req_i,
  input remap_pkg::resp_t    slv_resp_i,  // observed upstream response
  input remap_pkg::mst_req_t mst_req_i,   // observed downstream request
  input remap_pkg::resp_t    mst_resp_i,
  input remap_pkg::rule_t    rules_i [`REMAP_NUM_RULES]
);

  logic table_empty; // high while no rule is valid and every address maps to itself

  always_comb begin
    table_empty = 1'b1;
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      if (rules_i[i].valid) begin
        table_empty = 1'b0;
      end
    end
  end

  // valids go downstream untouched
  valid_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {mst_req_i.aw_valid, mst_req_i.w_valid, mst_req_i.ar_valid} ==
    {slv_req_i.aw_valid, slv_req_i.w_valid, slv_req_i.ar_valid})
    else $error("request valids differ between slave and master port");

  // response readies too
  ready_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {mst_req_i.b_ready, mst_req_i.r_ready} == {slv_req_i.b_ready, slv_req_i.r_ready})
    else $error("response readies differ between slave and master port");

  // whole response bundle is a wire
  resp_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_resp_i == mst_resp_i)
    else $error("slave response differs from master response");

  identity_aw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    table_empty |-> mst_req_i.aw.addr == remap_pkg::mst_addr_t'(slv_req_i.aw.addr))
    else $error("AW address not zero-extended while no rule is valid");

  identity_ar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    table_empty |-> mst_req_i.ar.addr == remap_pkg::mst_addr_t'(slv_req_i.ar.addr))
    else $error("AR address not zero-extended while no rule is valid");

endmodule

bind axi_addr_remap_top remap_sva i_remap_sva (
  .clk_i      ( clk_i      ),
  .rst_n_i    ( rst_n_i    ),
  .slv_req_i  ( slv_req_i  ),
  .slv_resp_i ( slv_resp_o ),
  .mst_req_i  ( mst_req_o  ),
  .mst_resp_i ( mst_resp_i ),
  .rules_i    ( rules      )
);

// ==== dv/tb_axi_addr_remap.sv ====
// testbench top with clock, reset, stimulus table, reference model, checks and watchdog
`timescale 1ns/1ns
`include "remap_consts.svh"

module tb_axi_addr_remap;

  localparam int CLK_PERIOD       = 4;  // ns
  localparam int RESET_CYCLES     = 4;
  localparam int CYCLES_PER_ENTRY = 10; // watchdog budget per table row

  typedef logic [255:0] wide_t; // common width for compares and random fill

  // one table row with an optional rule write and one request
  typedef struct packed {
    logic                 cfg_en;
    remap_pkg::rule_idx_t cfg_idx;
    remap_pkg::rule_t     cfg_rule;
    logic                 aw_valid;
    remap_pkg::slv_addr_t aw_addr;
    logic                 ar_valid;
    remap_pkg::slv_addr_t ar_addr;
    remap_pkg::mst_addr_t exp_aw;   // from the model
    remap_pkg::mst_addr_t exp_ar;
  } entry_t;

  logic                 clk;
  logic                 rst_n;
  remap_pkg::rule_cfg_t cfg;
  remap_pkg::slv_req_t  slv_req;
  remap_pkg::resp_t     slv_resp;
  remap_pkg::mst_req_t  mst_req;
  remap_pkg::resp_t     mst_resp;

  entry_t           stim [$];                         // the stimulus table
  remap_pkg::rule_t model_rules [`REMAP_NUM_RULES];   // model copy of the table
  bit               table_ready;

  axi_addr_remap_top uut (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .cfg_i      ( cfg      ),
    .slv_req_i  ( slv_req  ),
    .slv_resp_o ( slv_resp ),
    .mst_req_o  ( mst_req  ),
    .mst_resp_i ( mst_resp )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // limit scales with the table
  initial begin
    wait (table_ready);
    #((stim.size() * CYCLES_PER_ENTRY + RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired, %0d table rows did not finish in time", stim.size());
    $display("RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  task automatic stop_on_error();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input wide_t got, input wide_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic wide_t random_wide();
    wide_t v;
    for (int i = 0; i < $bits(wide_t) / 32; i++) begin
      v[i*32 +: 32] = $urandom();
    end
    return v;
  endfunction

  function automatic remap_pkg::rule_t make_rule(input logic valid,
                                                 input remap_pkg::slv_addr_t base,
                                                 input remap_pkg::slv_addr_t mask,
                                                 input remap_pkg::mst_addr_t target);
    remap_pkg::rule_t r;
    r.valid  = valid;
    r.base   = base;
    r.mask   = mask;
    r.target = target;
    return r;
  endfunction

  // first valid rule from index 0 whose masked bits equal the masked base
  function automatic remap_pkg::mst_addr_t model_remap(input remap_pkg::slv_addr_t addr);
    remap_pkg::slv_addr_t page_out;
    remap_pkg::slv_addr_t m;
    logic                 hit;
    page_out = addr;
    hit      = 1'b0;
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      m = model_rules[i].mask;
      if (!hit && model_rules[i].valid && ((addr ^ model_rules[i].base) & m) == '0) begin
        page_out = (model_rules[i].target[`REMAP_SLV_ADDR_W-1:0] & m) | (addr & ~m);
        hit      = 1'b1;
      end
    end
    return remap_pkg::mst_addr_t'(page_out); // upper 8 bits always zero
  endfunction

  task automatic add_entry(input logic cfg_en, input remap_pkg::rule_idx_t idx,
                           input remap_pkg::rule_t rule,
                           input logic aw_valid, input remap_pkg::slv_addr_t aw_addr,
                           input logic ar_valid, input remap_pkg::slv_addr_t ar_addr);
    entry_t e;
    if (cfg_en) begin
      model_rules[idx] = rule; // write lands before the request is driven
    end
    e.cfg_en   = cfg_en;
    e.cfg_idx  = idx;
    e.cfg_rule = rule;
    e.aw_valid = aw_valid;
    e.aw_addr  = aw_addr;
    e.ar_valid = ar_valid;
    e.ar_addr  = ar_addr;
    e.exp_aw   = model_remap(aw_addr);
    e.exp_ar   = model_remap(ar_addr);
    stim.push_back(e);
  endtask

  task automatic build_table();
    remap_pkg::rule_t     none;
    remap_pkg::rule_t     page8;      // 0x8xxx_xxxx -> 0x3xxx_xxxx
    remap_pkg::rule_t     page81;     // 0x81xx_xxxx -> 0xC2xx_xxxx
    remap_pkg::rule_t     page81_off;
    remap_pkg::rule_t     rnd_rule;
    remap_pkg::slv_addr_t rnd_base;
    none       = '0;
    page8      = make_rule(1'b1, 32'h8000_0000, 32'hF000_0000, 40'h00_3000_0000);
    page81     = make_rule(1'b1, 32'h8100_0000, 32'hFF00_0000, 40'h00_C200_0000);
    page81_off = page81;
    page81_off.valid = 1'b0;
    for (int i = 0; i < `REMAP_NUM_RULES; i++) begin
      model_rules[i] = '0; // reset state
    end
    // random addresses through the empty table
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 2'd0, none, 1'b1, $urandom(), 1'b1, $urandom());
    end
    // single rule with AW hit (0x3123_4560) then AW miss
    add_entry(1'b1, 2'd1, page8, 1'b1, 32'h8123_4560, 1'b0, 32'h0000_0040);
    add_entry(1'b0, 2'd0, none, 1'b1, 32'h9000_0010, 1'b0, 32'h0000_0080);
    // AW and AR in one cycle where one hits and one misses
    add_entry(1'b0, 2'd0, none, 1'b1, 32'h8000_1000, 1'b1, 32'h4000_2000);
    add_entry(1'b0, 2'd0, none, 1'b1, 32'h7FFF_FFFC, 1'b1, 32'h8FFF_FFFC);
    // overlapping rule at index 0 wins -> 0xC200_ABCD
    add_entry(1'b1, 2'd0, page81, 1'b1, 32'h8100_ABCD, 1'b1, 32'h8200_0000);
    // rule 0 off so rule 1 takes over -> 0x3100_ABCD
    add_entry(1'b1, 2'd0, page81_off, 1'b1, 32'h8100_ABCD, 1'b1, 32'h8100_0004);
    add_entry(1'b1, 2'd1, none, 1'b1, 32'h8100_ABCD, 1'b1, 32'h8000_0000); // all off again
    // random 4 KiB page at index 2
    rnd_base = $urandom();
    rnd_rule = make_rule(1'b1, rnd_base, 32'hFFFF_F000,
                         remap_pkg::mst_addr_t'({$urandom(), $urandom()}));
    add_entry(1'b1, 2'd2, rnd_rule, 1'b1, {rnd_base[31:12], 12'($urandom())},
              1'b1, $urandom());
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 2'd0, none, 1'($urandom()), {rnd_base[31:12], 12'($urandom())},
                1'($urandom()), $urandom());
    end
  endtask

  // starts and ends on a falling edge
  task automatic apply_entry(input entry_t e);
    remap_pkg::slv_req_t req;
    remap_pkg::resp_t    resp;
    wide_t               rnd;
    if (e.cfg_en) begin
      cfg.en   = 1'b1;
      cfg.idx  = e.cfg_idx;
      cfg.rule = e.cfg_rule;
      @(negedge clk); // write edge in between
      cfg.en   = 1'b0;
    end
    rnd  = random_wide();
    req  = rnd[$bits(remap_pkg::slv_req_t)-1:0];  // random side fields
    rnd  = random_wide();
    resp = rnd[$bits(remap_pkg::resp_t)-1:0];
    req.aw.addr  = e.aw_addr;
    req.aw_valid = e.aw_valid;
    req.ar.addr  = e.ar_addr;
    req.ar_valid = e.ar_valid;
    slv_req  = req;
    mst_resp = resp;
    #1; // mid low phase with the combinational path settled
    check_val("mst_req.aw.addr", wide_t'(mst_req.aw.addr), wide_t'(e.exp_aw));
    check_val("mst_req.ar.addr", wide_t'(mst_req.ar.addr), wide_t'(e.exp_ar));
    check_val("mst_req.aw.id", wide_t'(mst_req.aw.id), wide_t'(req.aw.id));
    check_val("mst_req.aw.len", wide_t'(mst_req.aw.len), wide_t'(req.aw.len));
    check_val("mst_req.aw.burst", wide_t'(mst_req.aw.burst), wide_t'(req.aw.burst));
    check_val("mst_req.aw.user", wide_t'(mst_req.aw.user), wide_t'(req.aw.user));
    check_val("mst_req.aw.atop", wide_t'(mst_req.aw.atop), wide_t'(req.aw.atop));
    check_val("mst_req.aw size/lock/cache/prot/qos/region",
              wide_t'({mst_req.aw.size, mst_req.aw.lock, mst_req.aw.cache,
                       mst_req.aw.prot, mst_req.aw.qos, mst_req.aw.region}),
              wide_t'({req.aw.size, req.aw.lock, req.aw.cache,
                       req.aw.prot, req.aw.qos, req.aw.region}));
    check_val("mst_req.ar.id", wide_t'(mst_req.ar.id), wide_t'(req.ar.id));
    check_val("mst_req.ar.len", wide_t'(mst_req.ar.len), wide_t'(req.ar.len));
    check_val("mst_req.ar.burst", wide_t'(mst_req.ar.burst), wide_t'(req.ar.burst));
    check_val("mst_req.ar.user", wide_t'(mst_req.ar.user), wide_t'(req.ar.user));
    check_val("mst_req.ar size/lock/cache/prot/qos/region",
              wide_t'({mst_req.ar.size, mst_req.ar.lock, mst_req.ar.cache,
                       mst_req.ar.prot, mst_req.ar.qos, mst_req.ar.region}),
              wide_t'({req.ar.size, req.ar.lock, req.ar.cache,
                       req.ar.prot, req.ar.qos, req.ar.region}));
    check_val("mst_req.w", wide_t'(mst_req.w), wide_t'(req.w));
    check_val("mst_req valids/readies",
              wide_t'({mst_req.aw_valid, mst_req.w_valid, mst_req.b_ready,
                       mst_req.ar_valid, mst_req.r_ready}),
              wide_t'({req.aw_valid, req.w_valid, req.b_ready, req.ar_valid, req.r_ready}));
    check_val("slv_resp", wide_t'(slv_resp), wide_t'(resp));
    @(negedge clk);
  endtask

  initial begin
    table_ready = 1'b0;
    void'($urandom(27)); // single seed for the run
    rst_n       = 1'b0;
    cfg         = '0;
    slv_req     = '0;
    mst_resp    = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/remap_pkg.sv
verilog/remap_rule_regs.sv
verilog/addr_translate.sv
verilog/axi_modify_address.sv
verilog/axi_addr_remap_top.sv
dv/remap_sva.sv
dv/tb_axi_addr_remap.sv

// ==== Bender.yml ====
package:
  name: axi_addr_remap

export_include_dirs:
  - verilog

sources:
  # design, in compile order
  - include_dirs:
      - verilog
    files:
      - verilog/remap_pkg.sv
      - verilog/remap_rule_regs.sv
      - verilog/addr_translate.sv
      - verilog/axi_modify_address.sv
      - verilog/axi_addr_remap_top.sv

  # testbench with bound assertions
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/remap_sva.sv
      - dv/tb_axi_addr_remap.sv
